//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f z3_card.f --top-module tb_z3_card -o tb_z3_card

status=0
./obj_dir/tb_z3_card +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation did not finish cleanly"
	exit 1
fi
echo "simulation passed"

//--- src/z3_autoconfig.sv
// zorro III autoconfig only; base is the 64 MB slot in A31..A26, no zorro II mode
`include "z3_macros.svh"

module z3_autoconfig (
	input  logic              clk,
	input  logic              nIORST,
	input  z3_pkg::z3_cycle_s cycle_i,
	input  logic              cfg_wr_i,
	input  logic [31:0]       wdata_i,
	input  logic              cfgin_n_i,
	output logic [3:0]        rnib_o,
	output logic [5:0]        base_o,
	output logic              cfg_open_o,
	output logic              configured_o,
	output logic              cfgout_n_o
);
	import z3_pkg::*;

	logic [5:0] base_q;
	logic       configured_q;
	logic       shutup_q;
	logic [8:0] reg_off;

	// byte offset inside config space
	assign reg_off = {cycle_i.addr[8:2], 2'b00};

	// ----------------------------------------
	// read side
	// ----------------------------------------
	// table covers 0x00..0x3C, the rest reads as all ones
	always_comb begin
		if (cycle_i.addr[8:6] == 3'b000) begin
			rnib_o = cfg_rom[cycle_i.addr[5:2]];
		end else begin
			rnib_o = 4'hF;
		end
	end

	// ----------------------------------------
	// write side
	// ----------------------------------------
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			base_q       <= '0;
			configured_q <= 1'b0;
			shutup_q     <= 1'b0;
		end else if (cfg_wr_i) begin
			if (reg_off == `Z3_REG_BASE) begin
				// base address arrives on D31..D26
				base_q       <= wdata_i[31:26];
				configured_q <= 1'b1;
			end else if (reg_off == `Z3_REG_SHUTUP) begin
				shutup_q <= 1'b1;
			end
		end
	end

	assign base_o       = base_q;
	assign configured_o = configured_q;
	// respond in config space only while it is our turn in the chain
	assign cfg_open_o   = !cfgin_n_i && !configured_q && !shutup_q;
	// pass the chain on once configured or told to shut up
	assign cfgout_n_o   = !(configured_q || shutup_q);

endmodule

//--- src/z3_bus_front.sv
// bus inputs are asynchronous to clk; address must stay valid until the synchronized /FCS falls
`include "z3_macros.svh"

module z3_bus_front (
	input  logic              clk,
	input  logic              nIORST,
	input  logic              fcs_n_i,
	input  logic              doe_i,
	input  logic              read_i,
	input  logic [3:0]        ds_n_i,
	input  logic [31:8]       ad_i,
	input  logic [7:2]        a_i,
	input  logic [7:0]        sd_i,
	input  logic [1:0]        fc_i,
	input  logic [5:0]        base_i,
	input  logic              cfg_open_i,
	input  logic              configured_i,
	output z3_pkg::z3_bus_s   bus_o,
	output z3_pkg::z3_cycle_s cycle_o,
	output logic              hit_o
);
	import z3_pkg::*;

	// strobes idle high after reset
	localparam z3_bus_s BUS_IDLE = '{fcs_n: 1'b1, ds_n: 4'hF, default: '0};

	z3_bus_s   raw_bus;
	z3_bus_s   sync_q [`Z3_SYNC_STAGES];
	z3_cycle_s cycle_q;
	z3_space_e space;
	logic      fcs_prev_q;
	logic      hit_q;

	assign raw_bus = '{fcs_n: fcs_n_i, doe: doe_i, read: read_i, ds_n: ds_n_i,
		ad: ad_i, a: a_i, sd: sd_i, fc: fc_i};
	assign bus_o = sync_q[`Z3_SYNC_STAGES-1];

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	always_comb begin
		space = SP_NONE;
		// config space at $FF000000, only while our turn in the chain
		if (cfg_open_i && bus_o.ad[31:16] == 16'hFF00) begin
			space = SP_CFG;
		end else if (configured_i && bus_o.ad[31:26] == base_i) begin
			space = SP_CARD;
		end
	end

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			for (int i = 0; i < `Z3_SYNC_STAGES; i++) begin
				sync_q[i] <= BUS_IDLE;
			end
			cycle_q    <= '{addr: '0, space: SP_NONE};
			fcs_prev_q <= 1'b1;
			hit_q      <= 1'b0;
		end else begin
			sync_q[0] <= raw_bus;
			for (int i = 1; i < `Z3_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			fcs_prev_q <= bus_o.fcs_n;
			// latch on the synchronized falling edge of /FCS
			if (!bus_o.fcs_n && fcs_prev_q) begin
				cycle_q <= '{addr: {bus_o.ad, bus_o.a}, space: space};
			end
			// one cycle after the latch, fc must be 01 or 10
			hit_q <= !bus_o.fcs_n && !fcs_prev_q && (cycle_q.space != SP_NONE) && (^bus_o.fc);
		end
	end

	assign cycle_o = cycle_q;
	assign hit_o   = hit_q;

endmodule

//--- src/z3_card.sv
// zorro III slave with on-chip memory; no tristate pads, data leaves as value plus enable
module z3_card (
	input  logic        clk,
	input  logic        nIORST,
	input  logic        fcs_n_i,
	input  logic        doe_i,
	input  logic        read_i,
	input  logic [3:0]  ds_n_i,
	input  logic [31:8] ad_i,
	input  logic [7:2]  a_i,
	input  logic [7:0]  sd_i,
	input  logic [1:0]  fc_i,
	input  logic        berr_n_i,
	input  logic        cfgin_n_i,
	output logic        slave_n_o,
	output logic        dtack_n_o,
	output logic        cfgout_n_o,
	output logic [31:0] data_o,
	output logic        data_oe_o
);
	import z3_pkg::*;

	z3_bus_s     bus;
	z3_cycle_s   cycle;
	z3_state_e   state;
	z3_mem_req_s mem_req;
	logic        hit;
	logic        mem_stb;
	logic        cfg_wr;
	logic        mem_ack;
	logic [31:0] mem_rdata;
	logic [31:0] wdata;
	logic        delay_done;
	logic        timeout;
	logic [3:0]  rnib;
	logic [5:0]  base;
	logic        cfg_open;
	logic        configured;

	// ----------------------------------------
	// bus side
	// ----------------------------------------
	z3_bus_front i_front (
		.clk(clk), .nIORST(nIORST), .fcs_n_i(fcs_n_i), .doe_i(doe_i), .read_i(read_i),
		.ds_n_i(ds_n_i), .ad_i(ad_i), .a_i(a_i), .sd_i(sd_i), .fc_i(fc_i),
		.base_i(base), .cfg_open_i(cfg_open), .configured_i(configured),
		.bus_o(bus), .cycle_o(cycle), .hit_o(hit)
	);

	z3_cycle_fsm i_fsm (
		.clk(clk), .nIORST(nIORST), .bus_i(bus), .cycle_i(cycle), .hit_i(hit),
		.mem_ack_i(mem_ack), .delay_done_i(delay_done), .timeout_i(timeout),
		.state_o(state), .mem_stb_o(mem_stb), .cfg_wr_o(cfg_wr),
		.slave_n_o(slave_n_o), .dtack_n_o(dtack_n_o)
	);

	z3_dtack_timer i_timer (
		.clk(clk), .nIORST(nIORST), .state_i(state),
		.delay_done_o(delay_done), .timeout_o(timeout)
	);

	z3_autoconfig i_autoconfig (
		.clk(clk), .nIORST(nIORST), .cycle_i(cycle), .cfg_wr_i(cfg_wr), .wdata_i(wdata),
		.cfgin_n_i(cfgin_n_i), .rnib_o(rnib), .base_o(base), .cfg_open_o(cfg_open),
		.configured_o(configured), .cfgout_n_o(cfgout_n_o)
	);

	// ----------------------------------------
	// data and memory
	// ----------------------------------------
	z3_data_path i_data (
		.clk(clk), .nIORST(nIORST), .bus_i(bus), .cycle_i(cycle), .state_i(state),
		.mem_stb_i(mem_stb), .rnib_i(rnib), .mem_rdata_i(mem_rdata), .mem_ack_i(mem_ack),
		.berr_n_i(berr_n_i), .slave_n_i(slave_n_o), .doe_i(doe_i), .read_i(read_i),
		.mem_req_o(mem_req), .wdata_o(wdata), .data_o(data_o), .data_oe_o(data_oe_o)
	);

	z3_local_ram i_ram (
		.clk(clk), .nIORST(nIORST), .req_i(mem_req),
		.rdata_o(mem_rdata), .ack_o(mem_ack)
	);

endmodule

//--- src/z3_cycle_fsm.sv
// one slave cycle at a time; a rise of the synchronized /FCS aborts any state
module z3_cycle_fsm (
	input  logic              clk,
	input  logic              nIORST,
	input  z3_pkg::z3_bus_s   bus_i,
	input  z3_pkg::z3_cycle_s cycle_i,
	input  logic              hit_i,
	input  logic              mem_ack_i,
	input  logic              delay_done_i,
	input  logic              timeout_i,
	output z3_pkg::z3_state_e state_o,
	output logic              mem_stb_o,
	output logic              cfg_wr_o,
	output logic              slave_n_o,
	output logic              dtack_n_o
);
	import z3_pkg::*;

	z3_state_e state_q;
	z3_state_e state_d;
	logic      stb_q;
	logic      stb_d;
	logic      cfg_wr_q;
	logic      cfg_wr_d;
	logic      is_cfg;

	assign is_cfg = (cycle_i.space == SP_CFG);

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_d  = state_q;
		stb_d    = 1'b0;
		cfg_wr_d = 1'b0;
		if (bus_i.fcs_n) begin
			// master ended the cycle
			state_d = ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (hit_i) begin
						state_d = ST_MATCH;
					end
				end
				ST_MATCH: begin
					// wait for data time
					if (bus_i.doe) begin
						state_d = ST_DATA;
					end
				end
				ST_DATA: begin
					if (bus_i.read) begin
						// config reads come from the nibble table
						if (is_cfg) begin
							state_d = ST_DTACK_DELAY;
						end else begin
							stb_d   = 1'b1;
							state_d = ST_MEM_WAIT;
						end
					end else if (bus_i.ds_n != 4'hF) begin
						// write data valid once any strobe is low
						state_d = ST_WRITE_STB;
					end
				end
				ST_WRITE_STB: begin
					if (is_cfg) begin
						cfg_wr_d = 1'b1;
						state_d  = ST_DTACK_DELAY;
					end else begin
						stb_d   = 1'b1;
						state_d = ST_MEM_WAIT;
					end
				end
				ST_MEM_WAIT: begin
					if (mem_ack_i) begin
						state_d = ST_DTACK_DELAY;
					end
				end
				ST_DTACK_DELAY: begin
					if (delay_done_i) begin
						state_d = ST_DTACK;
					end
				end
				ST_DTACK: begin
					// master never ended the cycle
					if (timeout_i) begin
						state_d = ST_DTACK_ERR;
					end
				end
				default: begin
					// ST_DTACK_ERR holds until /FCS rises
					state_d = state_q;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			state_q  <= ST_IDLE;
			stb_q    <= 1'b0;
			cfg_wr_q <= 1'b0;
		end else begin
			state_q  <= state_d;
			stb_q    <= stb_d;
			cfg_wr_q <= cfg_wr_d;
		end
	end

	assign state_o   = state_q;
	assign mem_stb_o = stb_q;
	assign cfg_wr_o  = cfg_wr_q;
	assign slave_n_o = !hit_i;
	// /DTACK follows the state alone
	assign dtack_n_o = !(state_q == ST_DTACK);

endmodule

//--- src/z3_data_path.sv
// word order is D31..D0 = AD31..24, SD7..0, AD23..8; output enable uses the raw doe/read pins
`include "z3_macros.svh"

module z3_data_path (
	input  logic                clk,
	input  logic                nIORST,
	input  z3_pkg::z3_bus_s     bus_i,
	input  z3_pkg::z3_cycle_s   cycle_i,
	input  z3_pkg::z3_state_e   state_i,
	input  logic                mem_stb_i,
	input  logic [3:0]          rnib_i,
	input  logic [31:0]         mem_rdata_i,
	input  logic                mem_ack_i,
	input  logic                berr_n_i,
	input  logic                slave_n_i,
	input  logic                doe_i,
	input  logic                read_i,
	output z3_pkg::z3_mem_req_s mem_req_o,
	output logic [31:0]         wdata_o,
	output logic [31:0]         data_o,
	output logic                data_oe_o
);
	import z3_pkg::*;

	logic [31:0] wdata_q;
	logic [3:0]  be_q;
	logic [31:0] rdata_q;

	// write word and byte mask, taken in ST_WRITE_STB
	always_ff @(posedge clk) begin
		if (state_i == ST_WRITE_STB) begin
			wdata_q <= {bus_i.ad[31:24], bus_i.sd, bus_i.ad[23:8]};
			be_q    <= ~bus_i.ds_n;
		end
	end

	// read word held until the next read
	always_ff @(posedge clk) begin
		if (state_i == ST_DATA && cycle_i.space == SP_CFG) begin
			rdata_q <= {rnib_i, 28'hFFF_FFFF};
		end else if (mem_ack_i && bus_i.read) begin
			rdata_q <= mem_rdata_i;
		end
	end

	assign mem_req_o = '{stb: mem_stb_i, we: !bus_i.read, be: be_q,
		addr: cycle_i.addr[`Z3_RAM_AW+1:2], wdata: wdata_q};
	assign wdata_o = wdata_q;
	assign data_o  = rdata_q;
	// off the bus at once on /BERR or when the master takes data time back
	assign data_oe_o = !slave_n_i && doe_i && read_i && berr_n_i;

endmodule

//--- src/z3_dtack_timer.sv
// one counter serves both limits; it restarts on entry to ST_DTACK_DELAY and ST_DTACK
`include "z3_macros.svh"

module z3_dtack_timer (
	input  logic              clk,
	input  logic              nIORST,
	input  z3_pkg::z3_state_e state_i,
	output logic              delay_done_o,
	output logic              timeout_o
);
	import z3_pkg::*;

	localparam int CW = $clog2(`Z3_DTACK_TIMEOUT + 1);

	z3_state_e prev_q;
	logic [CW-1:0] cnt_q;
	logic [CW-1:0] cnt;
	logic entering;

	// cycles already spent in the current timed state
	assign entering = (state_i != prev_q) &&
		(state_i == ST_DTACK_DELAY || state_i == ST_DTACK);
	assign cnt = entering ? '0 : cnt_q;

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			prev_q <= ST_IDLE;
			cnt_q  <= '0;
		end else begin
			prev_q <= state_i;
			// saturate instead of wrapping in ST_DTACK_ERR
			cnt_q  <= (cnt == '1) ? cnt : cnt + 1'b1;
		end
	end

	// flags raised one cycle early, the state changes on the next edge
	assign delay_done_o = (state_i == ST_DTACK_DELAY) && (cnt == CW'(`Z3_DTACK_DELAY - 1));
	assign timeout_o    = (state_i == ST_DTACK) && (cnt == CW'(`Z3_DTACK_TIMEOUT - 1));

endmodule

//--- src/z3_local_ram.sv
// one request in flight; Z3_RAM_WAIT >= 2; contents are not cleared by reset
`include "z3_macros.svh"

module z3_local_ram (
	input  logic                clk,
	input  logic                nIORST,
	input  z3_pkg::z3_mem_req_s req_i,
	output logic [31:0]         rdata_o,
	output logic                ack_o
);
	localparam int WW = $clog2(`Z3_RAM_WAIT + 1);

	logic [31:0]   mem [2**`Z3_RAM_AW];
	logic [31:0]   rdata_q;
	logic [WW-1:0] wait_q;
	logic          ack_q;

	// ----------------------------------------
	// array with byte lanes
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (req_i.stb) begin
			// read first, so a write strobe returns the old word
			rdata_q <= mem[req_i.addr];
			if (req_i.we) begin
				for (int b = 0; b < 4; b++) begin
					if (req_i.be[b]) begin
						mem[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
					end
				end
			end
		end
	end

	// wait count, ack pulses when it runs out
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			wait_q <= '0;
			ack_q  <= 1'b0;
		end else begin
			ack_q <= (wait_q == WW'(1));
			if (req_i.stb) begin
				wait_q <= WW'(`Z3_RAM_WAIT - 1);
			end else if (wait_q != '0) begin
				wait_q <= wait_q - 1'b1;
			end
		end
	end

	assign rdata_o = rdata_q;
	assign ack_o   = ack_q;

endmodule

//--- src/z3_macros.svh
// timing and size constants; Z3_RAM_WAIT must be at least 2, delays count clk cycles
`ifndef Z3_MACROS_SVH
`define Z3_MACROS_SVH

// ----------------------------------------
// bus front end
// ----------------------------------------
// flops per bus input before use
`define Z3_SYNC_STAGES 2

// ----------------------------------------
// dtack timing, in clk cycles
// ----------------------------------------
`define Z3_DTACK_DELAY 4
// longest time /DTACK may stay low
`define Z3_DTACK_TIMEOUT 48

// ----------------------------------------
// local memory and autoconfig
// ----------------------------------------
// word address width, 256 words
`define Z3_RAM_AW 8
// strobe to acknowledge
`define Z3_RAM_WAIT 2
// autoconfig write offsets within config space
`define Z3_REG_BASE 9'h044
`define Z3_REG_SHUTUP 9'h04C

`endif

//--- src/z3_pkg.sv
// shared types for the card; cfg_rom holds nibbles as they appear on D31..D28, already inverted
`include "z3_macros.svh"

package z3_pkg;

	// ----------------------------------------
	// enums
	// ----------------------------------------
	// one zorro III slave cycle
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_MATCH,
		ST_DATA,
		ST_WRITE_STB,
		ST_MEM_WAIT,
		ST_DTACK_DELAY,
		ST_DTACK,
		ST_DTACK_ERR
	} z3_state_e;

	// decoded target of the cycle
	typedef enum logic [1:0] {
		SP_NONE,
		SP_CARD,
		SP_CFG
	} z3_space_e;

	// ----------------------------------------
	// structs
	// ----------------------------------------
	// bus inputs after the synchronizer
	typedef struct packed {
		logic        fcs_n;
		logic        doe;
		logic        read;
		logic [3:0]  ds_n;
		logic [31:8] ad;
		logic [7:2]  a;
		logic [7:0]  sd;
		logic [1:0]  fc;
	} z3_bus_s;

	// latched at the fall of /FCS
	typedef struct packed {
		logic [31:2] addr;
		z3_space_e   space;
	} z3_cycle_s;

	// local memory port, be is active high
	typedef struct packed {
		logic                    stb;
		logic                    we;
		logic [3:0]              be;
		logic [`Z3_RAM_AW-1:0]   addr;
		logic [31:0]             wdata;
	} z3_mem_req_s;

	// autoconfig nibbles at offsets 0x00..0x3C
	// type and flags first, then product, vendor and serial
	localparam logic [3:0] cfg_rom [16] = '{
		4'hA, 4'hC, 4'h7, 4'hE,
		4'hF, 4'h9, 4'hF, 4'hF,
		4'hE, 4'hD, 4'hB, 4'h7,
		4'hF, 4'hF, 4'hF, 4'hF
	};

endpackage

//--- tb/tb_z3_card.sv
// bus master model on the falling edge; memory contents are only known where written first
`include "z3_macros.svh"

module tb_z3_card;
	timeunit 1ns;
	timeprecision 1ps;
	import z3_pkg::*;

	// loop bounds in clk cycles
	localparam int SLAVE_WAIT   = 16;
	localparam int DTACK_WAIT   = 40;
	localparam int RELEASE_WAIT = 20;
	localparam int NUM_WORDS    = 12;
	// /DS patterns with contiguous low strobes
	localparam logic [3:0] DS_PICK [10] = '{
		4'h0, 4'h8, 4'h1, 4'hC, 4'h3, 4'h9, 4'h7, 4'hB, 4'hD, 4'hE
	};

	logic        clk;
	logic        nIORST;
	logic        fcs_n;
	logic        doe;
	logic        read;
	logic [3:0]  ds_n;
	logic [31:8] ad;
	logic [7:2]  a;
	logic [7:0]  sd;
	logic [1:0]  fc;
	logic        berr_n;
	logic        cfgin_n;
	logic        slave_n;
	logic        dtack_n;
	logic        cfgout_n;
	logic [31:0] data;
	logic        data_oe;
	int          seed;
	logic [5:0]  base;
	logic [31:0] model [256];

	z3_card i_dut (
		.clk(clk), .nIORST(nIORST), .fcs_n_i(fcs_n), .doe_i(doe), .read_i(read),
		.ds_n_i(ds_n), .ad_i(ad), .a_i(a), .sd_i(sd), .fc_i(fc), .berr_n_i(berr_n),
		.cfgin_n_i(cfgin_n), .slave_n_o(slave_n), .dtack_n_o(dtack_n),
		.cfgout_n_o(cfgout_n), .data_o(data), .data_oe_o(data_oe)
	);

	bind z3_card z3_card_asserts i_asserts (
		.clk(clk), .nIORST(nIORST), .fcs_n_i(fcs_n_i), .read_i(read_i),
		.slave_n_i(slave_n_o), .dtack_n_i(dtack_n_o), .cfgout_n_i(cfgout_n_o),
		.data_oe_i(data_oe_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// ----------------------------------------
	// reporting
	// ----------------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare_word(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			abort_run($sformatf("FAIL %s: expected %08h, actual %08h", name, exp, act));
		end
	endtask

	task automatic check_assert_count();
		if (i_dut.i_asserts.fail_cnt != 0) begin
			abort_run("a bound assertion on the card pins failed");
		end
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	// low /DS[b] replaces byte b, DS3 is D31..D24
	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdat,
		input logic [3:0] strobes);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (!strobes[b]) begin
				res[8*b +: 8] = wdat[8*b +: 8];
			end
		end
		return res;
	endfunction

	// word index in A9..A2, the bits between base and index are don't care
	function automatic logic [31:0] card_addr(input logic [7:0] idx);
		logic [15:0] mid;
		mid = 16'($random(seed));
		return {base, mid, idx, 2'b00};
	endfunction

	// ----------------------------------------
	// bus master
	// ----------------------------------------
	task automatic run_cycle(input logic [31:0] addr, input logic [1:0] fcode, input logic rd,
		input logic [3:0] strobes, input logic [31:0] wdat, input bit expect_ack,
		input bit hold, output logic [31:0] rdat);
		int n;
		rdat = '0;
		// address phase
		@(negedge clk);
		ad   = addr[31:8];
		a    = addr[7:2];
		fc   = fcode;
		read = rd;
		@(negedge clk);
		fcs_n = 1'b0;
		n = 0;
		while (slave_n && n < SLAVE_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (!expect_ack) begin
			if (!slave_n) begin
				abort_run("card claimed a cycle that is not addressed to it");
			end
		end else begin
			if (slave_n) begin
				abort_run("no /SLAVEN within the slave wait limit");
			end
			// data phase, write data on the lanes before the strobes
			if (!rd) begin
				ad = {wdat[31:24], wdat[15:0]};
				sd = wdat[23:16];
			end
			doe = 1'b1;
			@(negedge clk);
			ds_n = strobes;
			n = 0;
			while (dtack_n && n < DTACK_WAIT) begin
				@(negedge clk);
				n++;
			end
			if (dtack_n) begin
				abort_run("no /DTACK within the acknowledge wait limit");
			end
			rdat = data;
			if (rd && !data_oe) begin
				abort_run("data output enable low during a read acknowledge");
			end
			// stuck master, card has to give up on its own
			if (hold) begin
				n = 0;
				while (!dtack_n && n < `Z3_DTACK_TIMEOUT + 8) begin
					@(negedge clk);
					n++;
				end
				if (!dtack_n) begin
					abort_run("/DTACK still low well after the timeout");
				end
			end
		end
		fcs_n = 1'b1;
		ds_n  = 4'hF;
		doe   = 1'b0;
		n = 0;
		while (!slave_n && n < RELEASE_WAIT) begin
			@(negedge clk);
			n++;
		end
		if (!slave_n) begin
			abort_run("/SLAVEN stayed low after /FCS rose");
		end
		check_assert_count();
	endtask

	task automatic z3_read(input string name, input logic [31:0] addr, input logic [1:0] fcode,
		input bit expect_ack, input bit hold, input logic [31:0] exp);
		logic [31:0] got;
		run_cycle(addr, fcode, 1'b1, 4'h0, 32'd0, expect_ack, hold, got);
		if (expect_ack) begin
			compare_word(name, exp, got);
		end
	endtask

	task automatic z3_write(input logic [31:0] addr, input logic [3:0] strobes,
		input logic [31:0] wdat);
		logic [31:0] unused_rdat;
		run_cycle(addr, 2'b01, 1'b0, strobes, wdat, 1'b1, 1'b0, unused_rdat);
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		logic [31:0] wdat;
		logic [3:0]  strobes;
		int          idx;
		seed    = 89138;
		nIORST  = 1'b0;
		fcs_n   = 1'b1;
		doe     = 1'b0;
		read    = 1'b0;
		ds_n    = 4'hF;
		ad      = '0;
		a       = '0;
		sd      = '0;
		fc      = 2'b01;
		berr_n  = 1'b1;
		cfgin_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		nIORST = 1'b1;

		// autoconfig table, other bits read as ones
		for (int i = 0; i < 16; i++) begin
			z3_read($sformatf("cfg read %02h", 4 * i), 32'hFF00_0000 | 32'(4 * i), 2'b01,
				1'b1, 1'b0, {cfg_rom[i], 28'hFFF_FFFF});
		end

		// base write passes the chain on and closes config space
		base = 6'($random(seed));
		z3_write(32'hFF00_0044, 4'h0, {base, 26'd0});
		compare_word("cfgout_n after base write", 32'd0, {31'd0, cfgout_n});
		z3_read("cfg read after base", 32'hFF00_0000, 2'b01, 1'b0, 1'b0, 32'd0);

		// full words first so every byte is known
		for (int k = 0; k < NUM_WORDS; k++) begin
			idx  = (k * 37) % 256;
			wdat = $random(seed);
			model[idx] = wdat;
			z3_write(card_addr(8'(idx)), 4'h0, wdat);
		end
		// then partial writes over them
		for (int k = 0; k < NUM_WORDS; k++) begin
			idx     = (k * 37) % 256;
			strobes = DS_PICK[$unsigned($random(seed)) % 10];
			wdat    = $random(seed);
			model[idx] = merge_bytes(model[idx], wdat, strobes);
			z3_write(card_addr(8'(idx)), strobes, wdat);
		end
		for (int k = 0; k < NUM_WORDS; k++) begin
			idx = (k * 37) % 256;
			z3_read($sformatf("ram word %02h", idx), card_addr(8'(idx)), 2'b01, 1'b1, 1'b0,
				model[idx]);
		end

		// wrong base, then reserved function codes
		z3_read("other base", {base ^ 6'h01, 26'h000_0100}, 2'b01, 1'b0, 1'b0, 32'd0);
		z3_read("fc 00", card_addr(8'h00), 2'b00, 1'b0, 1'b0, 32'd0);
		z3_read("fc 11", card_addr(8'h00), 2'b11, 1'b0, 1'b0, 32'd0);

		// master holds /FCS past the timeout, next read must work
		z3_read("read held past timeout", card_addr(8'd37), 2'b01, 1'b1, 1'b1, model[37]);
		z3_read("read after timeout", card_addr(8'd0), 2'b01, 1'b1, 1'b0, model[0]);

		if (i_dut.i_asserts.fail_cnt != 0) begin
			abort_run("a bound assertion on the card pins failed");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

//--- tb/z3_card_asserts.sv
// watches the card pins only; fail_cnt counts failed checks so the testbench can end the run
`include "z3_macros.svh"

module z3_card_asserts (
	input logic clk,
	input logic nIORST,
	input logic fcs_n_i,
	input logic read_i,
	input logic slave_n_i,
	input logic dtack_n_i,
	input logic cfgout_n_i,
	input logic data_oe_i
);
	timeunit 1ns;
	timeprecision 1ps;

	int          fail_cnt = 0;
	logic        fcs_seen_q;
	int unsigned dtack_low_q;

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	// first /FCS since reset, and length of the current /DTACK pulse
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			fcs_seen_q  <= 1'b0;
			dtack_low_q <= 0;
		end else begin
			if (!fcs_n_i) begin
				fcs_seen_q <= 1'b1;
			end
			dtack_low_q <= dtack_n_i ? 0 : dtack_low_q + 1;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	// quiet card in reset and until the first cycle
	a_idle_after_reset: assert property (@(posedge clk)
		(!nIORST || !fcs_seen_q) |-> (slave_n_i && dtack_n_i && cfgout_n_i && !data_oe_i))
		else begin
			fail_cnt++;
			$error("card outputs active before the first bus cycle");
		end

	// no acknowledge without a claimed cycle
	a_dtack_needs_slave: assert property (@(posedge clk) disable iff (!nIORST)
		!dtack_n_i |-> !slave_n_i)
		else begin
			fail_cnt++;
			$error("/DTACK low while /SLAVEN is high");
		end

	// data drivers only on reads
	a_oe_only_on_read: assert property (@(posedge clk) disable iff (!nIORST)
		data_oe_i |-> read_i)
		else begin
			fail_cnt++;
			$error("data output enable high during a write");
		end

	// stuck cycle must release /DTACK
	a_dtack_bounded: assert property (@(posedge clk) disable iff (!nIORST)
		dtack_low_q <= `Z3_DTACK_TIMEOUT)
		else begin
			fail_cnt++;
			$error("/DTACK held low past the timeout");
		end

endmodule

//--- z3_card.f
+incdir+src
src/z3_pkg.sv
src/z3_bus_front.sv
src/z3_cycle_fsm.sv
src/z3_dtack_timer.sv
src/z3_autoconfig.sv
src/z3_local_ram.sv
src/z3_data_path.sv
src/z3_card.sv
tb/z3_card_asserts.sv
tb/tb_z3_card.sv
